// ==== rtl/boa_pkg.sv ====
// Shared opcode, funct3 and trap cause constants plus the pipeline barrier structs.
package boa_pkg;

    // Major opcodes, full 7-bit form of the 32-bit encoding.
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ALU functions.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Illegal instruction trap cause.
    localparam logic [3:0] ECAUSE_ILLEGAL = 4'd2;

    // ID/EX barrier contents.
    typedef struct packed {
        logic        valid;
        logic [31:1] pc;
        logic [31:0] insn;
        logic        use_rd;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic        branch;
        logic        branch_predict;
        logic        trap;
        logic [3:0]  cause;
    } idex_t;

    // EX/MEM barrier contents.
    typedef struct packed {
        logic        valid;
        logic [31:1] pc;
        logic [31:0] insn;
        logic        use_rd;
        // ALU result, link value or memory address.
        logic [31:0] result;
        logic [31:0] store_data;
        logic        trap;
        logic [3:0]  cause;
    } exmem_t;

    // Fetch restart request.
    typedef struct packed {
        logic        valid;
        logic [31:1] target;
    } redirect_t;

endpackage

// ==== rtl/boa_alu.sv ====
// Combinational RV32I integer ALU shared by register, immediate and address operations.
module boa_alu (
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    input  logic [2:0]  funct3,
    input  logic        alt,
    output logic [31:0] result
);
    import boa_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [31:0] shr;

    // Shift amount is the low five bits of operand B.
    assign shamt = op_b[4:0];

    // Adder doubles as subtractor when alt is set.
    assign sum = alt ? (op_a - op_b) : (op_a + op_b);

    // Set-less-than comparisons.
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // Right shift, arithmetic when alt is set.
    assign shr = alt ? 32'($signed(op_a) >>> shamt) : (op_a >> shamt);

    always_comb begin
        case (funct3)
            F3_ADD: begin
                result = sum;
            end
            F3_SLL: begin
                result = op_a << shamt;
            end
            F3_SLT: begin
                result = {31'b0, lt_signed};
            end
            F3_SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            F3_XOR: begin
                result = op_a ^ op_b;
            end
            F3_SR: begin
                result = shr;
            end
            F3_OR: begin
                result = op_a | op_b;
            end
            default: begin
                // Only AND remains.
                result = op_a & op_b;
            end
        endcase
    end

endmodule

// ==== rtl/boa_branch.sv ====
// Conditional branch evaluation against the ID stage prediction.
module boa_branch (
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [2:0]  funct3,
    input  logic        branch,
    input  logic        branch_predict,
    output logic        taken,
    output logic        mispredict
);
    import boa_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rs1_val == rs2_val;
    assign lt  = $signed(rs1_val) < $signed(rs2_val);
    assign ltu = rs1_val < rs2_val;

    // Condition per funct3; reserved encodings never branch.
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // Only conditional branches can be mispredicted.
    assign mispredict = branch && (taken != branch_predict);

endmodule

// ==== rtl/boa_stage_ex.sv ====
// EX pipeline stage computing results, addresses and redirects into the EX/MEM barrier.
module boa_stage_ex (
    input  logic               clk,
    input  logic               rst,
    input  boa_pkg::idex_t     d,
    input  logic               fw_stall_ex,
    input  logic               fw_stall_mem,
    output boa_pkg::exmem_t    q,
    output boa_pkg::redirect_t fw_redirect
);
    import boa_pkg::*;

    // Opcode without the length bits, so 16-bit forms decode the same.
    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic        is_jalr;
    logic        is_link;
    logic [31:0] pc_full;
    logic [31:0] link;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [2:0]  alu_funct3;
    logic        alu_alt;
    logic [31:0] alu_result;
    logic [31:0] result;
    logic        taken;
    logic        mispredict;
    logic        live;
    logic        redirect_now;
    logic [31:1] redirect_target;

    assign opcode  = d.insn[6:2];
    assign funct3  = d.insn[14:12];
    assign is_jalr = opcode == OP_JALR[6:2];
    assign is_link = is_jalr || (opcode == OP_JAL[6:2]);
    assign pc_full = {d.pc, 1'b0};

    // Link is the next sequential PC.
    assign link = (d.insn[1:0] == 2'b11) ? (pc_full + 32'd4) : (pc_full + 32'd2);

    // Immediate formats.
    assign imm_i = {{20{d.insn[31]}}, d.insn[31:20]};
    assign imm_s = {{20{d.insn[31]}}, d.insn[31:25], d.insn[11:7]};
    assign imm_b = {{19{d.insn[31]}}, d.insn[31], d.insn[7], d.insn[30:25], d.insn[11:8], 1'b0};
    assign imm_u = {d.insn[31:12], 12'b0};
    assign imm_j = {{11{d.insn[31]}}, d.insn[31], d.insn[19:12], d.insn[20], d.insn[30:21],
                    1'b0};

    // Immediate select by format.
    always_comb begin
        case (opcode)
            OP_LUI[6:2], OP_AUIPC[6:2]: imm = imm_u;
            OP_JAL[6:2]:                imm = imm_j;
            OP_BRANCH[6:2]:             imm = imm_b;
            OP_STORE[6:2]:              imm = imm_s;
            default:                    imm = imm_i;
        endcase
    end

    // PC-relative forms add to pc, everything else to rs1.
    assign op_a = (opcode == OP_AUIPC[6:2] || opcode == OP_JAL[6:2] ||
                   opcode == OP_BRANCH[6:2]) ? pc_full : d.rs1_val;
    assign op_b = (opcode == OP_REG[6:2]) ? d.rs2_val : imm;

    // Non-arithmetic opcodes use the ALU as an address adder.
    always_comb begin
        alu_funct3 = F3_ADD;
        alu_alt    = 1'b0;
        if (opcode == OP_REG[6:2]) begin
            alu_funct3 = funct3;
            alu_alt    = d.insn[30];
        end else if (opcode == OP_IMM[6:2]) begin
            // Bit 30 is part of the immediate except for right shifts.
            alu_funct3 = funct3;
            alu_alt    = d.insn[30] && (funct3 == F3_SR);
        end
    end

    boa_alu boa_alu_i (
        .op_a   (op_a),
        .op_b   (op_b),
        .funct3 (alu_funct3),
        .alt    (alu_alt),
        .result (alu_result)
    );

    boa_branch boa_branch_i (
        .rs1_val        (d.rs1_val),
        .rs2_val        (d.rs2_val),
        .funct3         (funct3),
        .branch         (d.branch),
        .branch_predict (d.branch_predict),
        .taken          (taken),
        .mispredict     (mispredict)
    );

    // Final result.
    always_comb begin
        if (opcode == OP_LUI[6:2]) begin
            result = imm_u;
        end else if (is_link) begin
            result = link;
        end else begin
            result = alu_result;
        end
    end

    // Trapped or empty slots never redirect.
    assign live         = d.valid && !d.trap;
    assign redirect_now = live && (is_jalr || mispredict);
    // ALU holds the JALR or taken target; dropping bit 0 masks JALR.
    assign redirect_target = (is_jalr || taken) ? alu_result[31:1] : link[31:1];

    // EX/MEM barrier.
    always_ff @(posedge clk) begin
        if (rst) begin
            q.valid           <= 1'b0;
            q.trap            <= 1'b0;
            fw_redirect.valid <= 1'b0;
        end else if (fw_stall_mem) begin
            // Hold q, but a redirect fires once only.
            fw_redirect.valid <= 1'b0;
        end else if (fw_stall_ex) begin
            // Bubble.
            q.valid           <= 1'b0;
            q.trap            <= 1'b0;
            fw_redirect.valid <= 1'b0;
        end else begin
            q.valid            <= live;
            q.pc               <= d.pc;
            q.insn             <= d.insn;
            q.use_rd           <= d.use_rd;
            q.result           <= result;
            q.store_data       <= d.rs2_val;
            q.trap             <= d.valid && d.trap;
            q.cause            <= d.cause;
            fw_redirect.valid  <= redirect_now;
            fw_redirect.target <= redirect_target;
        end
    end

endmodule

// ==== rtl/boa_ex_top.sv ====
// Top level of the EX subsystem; connects the EX stage to the external ports.
module boa_ex_top (
    input  logic               clk,
    input  logic               rst,
    // ID/EX barrier.
    input  boa_pkg::idex_t     d,
    // Hazard unit stall requests.
    input  logic               fw_stall_ex,
    input  logic               fw_stall_mem,
    // EX/MEM barrier.
    output boa_pkg::exmem_t    q,
    // Fetch restart.
    output boa_pkg::redirect_t fw_redirect
);

    boa_stage_ex boa_stage_ex_i (
        .clk          (clk),
        .rst          (rst),
        .d            (d),
        .fw_stall_ex  (fw_stall_ex),
        .fw_stall_mem (fw_stall_mem),
        .q            (q),
        .fw_redirect  (fw_redirect)
    );

endmodule

// ==== verif/boa_clkgen.sv ====
// Free-running testbench clock with an 8-unit period, starting low.
module boa_clkgen (
    output logic clk
);
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// ==== include/boa_ex_ref.svh ====
// Testbench model of the EX stage; include in the testbench to predict q and fw_redirect.
`ifndef BOA_EX_REF_SVH
`define BOA_EX_REF_SVH

// Expected EX/MEM contents for one unstalled capture; redir gets the redirect.
function automatic boa_pkg::exmem_t boa_ex_ref(input  boa_pkg::idex_t     d,
                                               output boa_pkg::redirect_t redir);
    boa_pkg::exmem_t e;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [31:0]     pc;
    logic [31:0]     link;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     ii;
    logic [31:0]     bi;
    logic            tk;

    opc  = {d.insn[6:2], 2'b11};
    f3   = d.insn[14:12];
    pc   = {d.pc, 1'b0};
    link = pc + ((d.insn[1:0] == 2'b11) ? 32'd4 : 32'd2);
    a    = d.rs1_val;
    b    = d.rs2_val;
    ii   = {{20{d.insn[31]}}, d.insn[31:20]};
    bi   = {{19{d.insn[31]}}, d.insn[31], d.insn[7], d.insn[30:25], d.insn[11:8], 1'b0};
    // Register forms use rs2, immediate forms the I immediate.
    if (opc == boa_pkg::OP_IMM) begin
        b = ii;
    end
    case (opc)
        boa_pkg::OP_LUI:    e.result = {d.insn[31:12], 12'b0};
        boa_pkg::OP_AUIPC:  e.result = pc + {d.insn[31:12], 12'b0};
        boa_pkg::OP_JAL, boa_pkg::OP_JALR: e.result = link;
        boa_pkg::OP_BRANCH: e.result = pc + bi;
        boa_pkg::OP_LOAD:   e.result = a + ii;
        boa_pkg::OP_STORE:  e.result = a + {{20{d.insn[31]}}, d.insn[31:25], d.insn[11:7]};
        boa_pkg::OP_IMM, boa_pkg::OP_REG: begin
            case (f3)
                3'd0: e.result = (opc == boa_pkg::OP_REG && d.insn[30]) ? a - b : a + b;
                3'd1: e.result = a << b[4:0];
                3'd2: e.result = {31'b0, $signed(a) < $signed(b)};
                3'd3: e.result = {31'b0, a < b};
                3'd4: e.result = a ^ b;
                3'd5: e.result = d.insn[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: e.result = a | b;
                default: e.result = a & b;
            endcase
        end
        default: e.result = a + ii;
    endcase
    case (f3)
        3'd0: tk = d.rs1_val == d.rs2_val;
        3'd1: tk = d.rs1_val != d.rs2_val;
        3'd4: tk = $signed(d.rs1_val) < $signed(d.rs2_val);
        3'd5: tk = $signed(d.rs1_val) >= $signed(d.rs2_val);
        3'd6: tk = d.rs1_val < d.rs2_val;
        3'd7: tk = d.rs1_val >= d.rs2_val;
        default: tk = 1'b0;
    endcase
    e.valid      = d.valid && !d.trap;
    e.pc         = d.pc;
    e.insn       = d.insn;
    e.use_rd     = d.use_rd;
    e.store_data = d.rs2_val;
    e.trap       = d.valid && d.trap;
    e.cause      = d.cause;
    redir.valid  = 1'b0;
    redir.target = tk ? 31'((pc + bi) >> 1) : 31'(link >> 1);
    if (opc == boa_pkg::OP_JALR) begin
        redir.valid  = e.valid;
        redir.target = 31'((a + ii) >> 1);
    end else if (d.branch && tk != d.branch_predict) begin
        redir.valid = e.valid;
    end
    return e;
endfunction

`endif

// ==== verif/tb_boa_ex.sv ====
// Self-checking testbench for boa_ex_top; random instructions and stalls go in on falling edges.
module tb_boa_ex;
    import boa_pkg::*;

    `include "boa_ex_ref.svh"

    // Expected barrier state after one rising edge.
    typedef struct packed {
        logic [2:0] tid;
        logic       loaded;
        exmem_t     e;
        redirect_t  r;
    } check_t;

    logic      clk;
    logic      rst;
    idex_t     d;
    logic      fw_stall_ex;
    logic      fw_stall_mem;
    exmem_t    q;
    redirect_t fw_redirect;

    check_t    check_q[$];
    // Model of the barrier; data fields are unknown until the first capture.
    exmem_t    exp_e = '0;
    redirect_t exp_r = '0;
    logic      loaded = 1'b0;
    int        checks = 0;
    int        value_errors = 0;
    int        other_errors = 0;

    boa_clkgen clkgen_i (.clk(clk));

    boa_ex_top boa_ex_top_i (
        .clk          (clk),
        .rst          (rst),
        .d            (d),
        .fw_stall_ex  (fw_stall_ex),
        .fw_stall_mem (fw_stall_mem),
        .q            (q),
        .fw_redirect  (fw_redirect)
    );

    function automatic string test_name(input logic [2:0] tid);
        case (tid)
            3'd1: return "alu";
            3'd2: return "upper_jump_mem";
            3'd3: return "branch";
            3'd4: return "trap";
            3'd5: return "stall";
            default: return "reset_idle";
        endcase
    endfunction

    // Register and immediate forms first, branch last.
    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            0: return OP_REG;
            1: return OP_IMM;
            2: return OP_LUI;
            3: return OP_AUIPC;
            4: return OP_JAL;
            5: return OP_JALR;
            6: return OP_LOAD;
            7: return OP_STORE;
            default: return OP_BRANCH;
        endcase
    endfunction

    // Random ID/EX entry; kind picks the opcode mix.
    function automatic idex_t make_insn(input logic [2:0] kind);
        idex_t      x;
        logic [6:0] opc;
        logic [2:0] f;
        x         = '0;
        x.valid   = 1'b1;
        x.pc      = 31'($urandom());
        x.insn    = $urandom();
        x.use_rd  = 1'($urandom());
        x.rs1_val = $urandom();
        // Occasional equal operands exercise BEQ, BGE and SLT corners.
        x.rs2_val = ($urandom() % 4 == 0) ? x.rs1_val : $urandom();
        case (kind)
            3'd1: opc = opcode_at(int'($urandom() % 2));
            3'd2: opc = opcode_at(2 + int'($urandom() % 6));
            3'd3: opc = OP_BRANCH;
            default: opc = opcode_at(int'($urandom() % 9));
        endcase
        x.insn[6:0] = opc;
        if (kind == 3'd3) begin
            // The six defined conditions are 0, 1, 4, 5, 6 and 7.
            f = 3'($urandom() % 6);
            x.insn[14:12] = (f < 3'd2) ? f : f + 3'd2;
        end
        // Some 16-bit encodings for the link value.
        if (kind == 3'd2 && $urandom() % 4 == 0) begin
            x.insn[1:0] = 2'($urandom() % 3);
        end
        if (kind == 3'd4) begin
            x.trap  = 1'b1;
            x.cause = ($urandom() % 2 == 0) ? ECAUSE_ILLEGAL : 4'($urandom());
        end
        if (kind == 3'd5) begin
            x.valid = ($urandom() % 8 != 0);
            x.trap  = ($urandom() % 8 == 0);
            x.cause = 4'($urandom());
        end
        x.branch         = (opc == OP_BRANCH);
        x.branch_predict = x.branch && 1'($urandom());
        return x;
    endfunction

    // Drives one cycle of inputs and queues what the barrier holds after the next edge.
    task automatic drive_cycle(input idex_t din, input logic r, input logic se,
                               input logic sm, input logic [2:0] tid);
        check_t    c;
        redirect_t rr;
        d            = din;
        rst          = r;
        fw_stall_ex  = se;
        fw_stall_mem = sm;
        if (r) begin
            exp_e.valid = 1'b0;
            exp_e.trap  = 1'b0;
            exp_r.valid = 1'b0;
        end else if (sm) begin
            // q holds; a redirect pulses once.
            exp_r.valid = 1'b0;
        end else if (se) begin
            exp_e.valid = 1'b0;
            exp_e.trap  = 1'b0;
            exp_r.valid = 1'b0;
        end else begin
            exp_e  = boa_ex_ref(din, rr);
            exp_r  = rr;
            loaded = 1'b1;
        end
        c.tid    = tid;
        c.loaded = loaded;
        c.e      = exp_e;
        c.r      = exp_r;
        check_q.push_back(c);
    endtask

    // Stalls and a short reset pulse only in the stall phase.
    task automatic run_phase(input logic [2:0] kind, input int count);
        idex_t din;
        logic  r;
        logic  se;
        logic  sm;
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            din = make_insn(kind);
            r   = (kind == 3'd5) && (n == 40 || n == 41);
            se  = (kind == 3'd5) && ($urandom() % 4 == 0);
            sm  = (kind == 3'd5) && ($urandom() % 4 == 0);
            drive_cycle(din, r, se, sm, kind);
        end
    endtask

    // Compare process runs a quarter period after each rising edge.
    initial begin
        check_t c;
        #1;
        forever begin
            @(posedge clk);
            #2;
            if (check_q.size() == 0) begin
                $display("Compare process found no expected value for this clock edge");
                other_errors++;
            end else begin
                c = check_q.pop_front();
                checks++;
                if (c.loaded && q !== c.e) begin
                    $display("** Error [%s] q: expected %h, actual %h",
                             test_name(c.tid), c.e, q);
                    value_errors++;
                end
                if (!c.loaded && {q.valid, q.trap} !== {c.e.valid, c.e.trap}) begin
                    $display("** Error [%s] q.valid/q.trap: expected %b, actual %b",
                             test_name(c.tid), {c.e.valid, c.e.trap}, {q.valid, q.trap});
                    value_errors++;
                end
                if (fw_redirect.valid !== c.r.valid) begin
                    $display("** Error [%s] fw_redirect.valid: expected %b, actual %b",
                             test_name(c.tid), c.r.valid, fw_redirect.valid);
                    value_errors++;
                end else if (c.r.valid && fw_redirect.target !== c.r.target) begin
                    $display("** Error [%s] fw_redirect.target: expected %h, actual %h",
                             test_name(c.tid), c.r.target, fw_redirect.target);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        idex_t blank;
        int    guard;
        blank = '0;
        void'($urandom(32'h8febee7f));
        // Reset held over the first 16 rising edges.
        drive_cycle(blank, 1'b1, 1'b0, 1'b0, 3'd0);
        #1;
        repeat (15) begin
            @(negedge clk);
            drive_cycle(blank, 1'b1, 1'b0, 1'b0, 3'd0);
        end
        run_phase(3'd1, 120);
        run_phase(3'd2, 120);
        run_phase(3'd3, 120);
        run_phase(3'd4, 40);
        run_phase(3'd5, 160);
        @(negedge clk);
        drive_cycle(blank, 1'b0, 1'b0, 1'b0, 3'd0);
        // Let the compare process catch up.
        guard = 0;
        while (check_q.size() != 0 && guard < 8) begin
            @(posedge clk);
            #3;
            guard++;
        end
        if (check_q.size() != 0) begin
            $display("Timed out waiting for the compare process to empty its queue");
            other_errors++;
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== boa_ex.f ====
+incdir+include
rtl/boa_pkg.sv
rtl/boa_alu.sv
rtl/boa_branch.sv
rtl/boa_stage_ex.sv
rtl/boa_ex_top.sv
verif/boa_clkgen.sv
verif/tb_boa_ex.sv
